// File: tl_pkg.sv
package tl_pkg;

    localparam int WORD_SIZE     = 32;
    localparam int REG_SIZE      = 5;
    localparam int DC_LINES      = 4;
    localparam int DC_INDEX_SIZE = 2;
    localparam int DC_BYTE_SIZE  = 4;                        // 16-byte lines
    localparam int DC_TAG_SIZE   = WORD_SIZE - DC_BYTE_SIZE;
    localparam int SB_DEPTH      = 2;
    localparam int SB_PTR_SIZE   = 1;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_type_e;

    typedef enum logic [1:0] {
        TL_IDLE,
        HAZARD_DC_MISS,
        HAZARD_SB_TROUBLE
    } tl_fsm_state_e;

    // Bundle from execute
    typedef struct packed {
        logic [WORD_SIZE-1:0] alu_res;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        logic [WORD_SIZE-1:0] st_data;
        logic                 memop_rd;
        logic                 memop_wr;
        logic                 sign_ext;
        memop_type_e          memop_type;
        logic                 tkbr;
        logic [WORD_SIZE-1:0] new_pc;
    } ex_tl_t;

    // Bundle toward the memory stage
    typedef struct packed {
        logic [WORD_SIZE-1:0]     alu_res;
        logic                     rf_we;
        logic [REG_SIZE-1:0]      rf_waddr;
        logic [DC_INDEX_SIZE-1:0] addr_index;
        logic                     memop_rd;
        logic                     memop_wr;
        logic                     sign_ext;
        memop_type_e              memop_type;
        logic                     tkbr;
        logic [WORD_SIZE-1:0]     new_pc;
        logic                     sb_hit;
        logic [WORD_SIZE-1:0]     sb_data;
    } tl_mem_t;

    typedef struct packed {
        logic                 valid;
        logic [WORD_SIZE-1:0] addr;     // Word aligned
        logic [3:0]           byte_en;
        logic [WORD_SIZE-1:0] data;
    } sb_flush_t;

endpackage

// File: dcache_tag.sv
module dcache_tag (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  logic [tl_pkg::DC_TAG_SIZE-1:0]   tag_i,
    input  logic                             fill_i,
    input  logic [tl_pkg::DC_INDEX_SIZE-1:0] fill_index_i,
    output logic                             hit_o,
    output logic                             miss_o,
    output logic [tl_pkg::DC_INDEX_SIZE-1:0] index_o
);

    logic [tl_pkg::DC_TAG_SIZE-1:0] tags_q [tl_pkg::DC_LINES];
    logic [tl_pkg::DC_LINES-1:0]    valid_q;
    logic [tl_pkg::DC_LINES-1:0]    match_vec;
    logic [tl_pkg::DC_TAG_SIZE-1:0] pending_tag_q;

    // Parallel compare against every line
    always_comb begin
        for (int i = 0; i < tl_pkg::DC_LINES; i++) begin
            match_vec[i] = valid_q[i] && (tags_q[i] == tag_i);
        end
    end

    always_comb begin
        index_o = '0;
        for (int i = 0; i < tl_pkg::DC_LINES; i++) begin
            if (match_vec[i]) begin
                index_o = i[tl_pkg::DC_INDEX_SIZE-1:0];
            end
        end
    end

    assign hit_o  = req_i && (|match_vec);
    assign miss_o = req_i && !(|match_vec);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_o) begin
            pending_tag_q <= tag_i;   // Held until the MMU answers
        end
        if (fill_i) begin
            tags_q[fill_index_i] <= pending_tag_q;
        end
    end

    // Fills only install tags that missed, so lines never alias
    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(match_vec))
        else $error("dcache_tag: more than one line matches");

endmodule

// File: sb_entry.sv
module sb_entry (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           alloc_i,
    input  logic                           merge_i,
    input  logic                           free_i,
    input  logic [tl_pkg::WORD_SIZE-3:0]   waddr_i,
    input  logic [3:0]                     byte_en_i,
    input  logic [tl_pkg::WORD_SIZE-1:0]   data_i,
    input  logic [3:0]                     load_byte_en_i,
    output logic                           valid_o,
    output logic                           match_o,
    output logic                           covers_o,
    output tl_pkg::sb_flush_t              entry_o
);

    logic                         valid_q;
    logic [tl_pkg::WORD_SIZE-3:0] waddr_q;
    logic [3:0]                   byte_en_q;
    logic [tl_pkg::WORD_SIZE-1:0] data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
        end else if (free_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            waddr_q   <= waddr_i;
            byte_en_q <= byte_en_i;
            data_q    <= data_i;
        end else if (merge_i) begin
            byte_en_q <= byte_en_q | byte_en_i;
            for (int b = 0; b < 4; b++) begin
                if (byte_en_i[b]) data_q[8*b +: 8] <= data_i[8*b +: 8];   // Newer byte wins
            end
        end
    end

    assign valid_o  = valid_q;
    assign match_o  = valid_q && (waddr_q == waddr_i);
    assign covers_o = (byte_en_q & load_byte_en_i) == load_byte_en_i;

    assign entry_o.valid   = valid_q;
    assign entry_o.addr    = {waddr_q, 2'b00};
    assign entry_o.byte_en = byte_en_q;
    assign entry_o.data    = data_q;

endmodule

// File: store_buffer.sv
module store_buffer (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         store_i,
    input  logic                         load_i,
    input  logic                         drain_i,
    input  logic [tl_pkg::WORD_SIZE-1:0] addr_i,
    input  logic [tl_pkg::WORD_SIZE-1:0] data_i,
    input  tl_pkg::memop_type_e          type_i,
    output logic                         hit_o,
    output logic                         trouble_o,
    output logic [tl_pkg::WORD_SIZE-1:0] load_data_o,
    output tl_pkg::sb_flush_t            head_o
);

    logic [3:0]                     byte_en;
    logic [tl_pkg::WORD_SIZE-1:0]   st_data;
    logic [tl_pkg::SB_DEPTH-1:0]    valid_vec;
    logic [tl_pkg::SB_DEPTH-1:0]    match_vec;
    logic [tl_pkg::SB_DEPTH-1:0]    covers_vec;
    logic [tl_pkg::SB_DEPTH-1:0]    alloc_vec;
    logic [tl_pkg::SB_DEPTH-1:0]    merge_vec;
    logic [tl_pkg::SB_DEPTH-1:0]    free_vec;
    tl_pkg::sb_flush_t              entries [tl_pkg::SB_DEPTH];
    logic [tl_pkg::SB_PTR_SIZE-1:0] head_q;
    logic [tl_pkg::SB_PTR_SIZE-1:0] tail_q;
    logic [tl_pkg::SB_PTR_SIZE-1:0] match_idx;
    logic                           any_match;
    logic                           full;
    logic                           store_we;

    // Access size and offset to lane mask
    always_comb begin
        case (type_i)
            tl_pkg::BYTE: byte_en = 4'b0001 << addr_i[1:0];
            tl_pkg::HALF: byte_en = 4'b0011 << {addr_i[1], 1'b0};
            default:      byte_en = 4'b1111;
        endcase
    end

    assign st_data = data_i << {addr_i[1:0], 3'b000};   // Move into byte lanes

    always_comb begin
        match_idx = '0;
        for (int i = 0; i < tl_pkg::SB_DEPTH; i++) begin
            if (match_vec[i]) match_idx = i[tl_pkg::SB_PTR_SIZE-1:0];
        end
    end

    assign any_match = |match_vec;
    assign full      = &valid_vec;

    // No room for a new word, or a partial overlap with a load
    assign trouble_o = (store_i && !any_match && full) ||
                       (load_i && any_match && !covers_vec[match_idx]);
    assign hit_o       = load_i && any_match && covers_vec[match_idx];
    assign load_data_o = entries[match_idx].data;
    assign head_o      = entries[head_q];
    assign store_we    = store_i && !trouble_o;

    for (genvar i = 0; i < tl_pkg::SB_DEPTH; i++) begin : g_entry
        assign alloc_vec[i] = store_we && !any_match && (int'(tail_q) == i);
        assign merge_vec[i] = store_we && match_vec[i];
        assign free_vec[i]  = drain_i && valid_vec[i] && (int'(head_q) == i);

        sb_entry u_entry (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .alloc_i        (alloc_vec[i]),
            .merge_i        (merge_vec[i]),
            .free_i         (free_vec[i]),
            .waddr_i        (addr_i[tl_pkg::WORD_SIZE-1:2]),
            .byte_en_i      (byte_en),
            .data_i         (st_data),
            .load_byte_en_i (byte_en),
            .valid_o        (valid_vec[i]),
            .match_o        (match_vec[i]),
            .covers_o       (covers_vec[i]),
            .entry_o        (entries[i])
        );
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (|free_vec) head_q <= head_q + 1'b1;
            if (|alloc_vec) tail_q <= tail_q + 1'b1;
        end
    end

    // Tail slot must be free whenever a new word is taken in
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|alloc_vec) |-> !valid_vec[tail_q])
        else $error("store_buffer: allocation over a valid entry");

endmodule

// File: tl_stage.sv
module tl_stage (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  tl_pkg::ex_tl_t                   ex_tl_i,
    input  logic                             mmu_data_rdy_i,
    input  logic [tl_pkg::DC_INDEX_SIZE-1:0] mmu_lru_index_i,
    output tl_pkg::tl_mem_t                  tl_mem_o,
    output tl_pkg::sb_flush_t                sb_flush_o,
    output logic                             mmu_miss_o,
    output logic [tl_pkg::WORD_SIZE-1:0]     mmu_addr_o,
    output logic                             pipeline_hazard_o
);

    tl_pkg::tl_fsm_state_e              state_q;
    tl_pkg::tl_fsm_state_e              state_d;
    logic                               memop;
    logic                               dc_req;
    logic                               dc_hit;
    logic                               dc_miss;
    logic [tl_pkg::DC_INDEX_SIZE-1:0]   dc_index;
    logic                               sb_hit;
    logic                               sb_trouble;
    logic                               sb_drain;
    logic [tl_pkg::WORD_SIZE-1:0]       sb_load_data;
    tl_pkg::sb_flush_t                  sb_head;
    logic                               load_miss;
    logic                               hazard;
    logic                               miss_req;
    tl_pkg::tl_mem_t                    mem_d;
    tl_pkg::tl_mem_t                    mem_q;
    tl_pkg::sb_flush_t                  flush_q;

    assign memop     = ex_tl_i.memop_rd || ex_tl_i.memop_wr;
    assign dc_req    = memop && (state_q != tl_pkg::HAZARD_DC_MISS);
    assign load_miss = ex_tl_i.memop_rd && !sb_hit && dc_miss;

    dcache_tag u_dcache_tag (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (dc_req),
        .tag_i        (ex_tl_i.alu_res[tl_pkg::WORD_SIZE-1:tl_pkg::DC_BYTE_SIZE]),
        .fill_i       (mmu_data_rdy_i),
        .fill_index_i (mmu_lru_index_i),
        .hit_o        (dc_hit),
        .miss_o       (dc_miss),
        .index_o      (dc_index)
    );

    store_buffer u_store_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .store_i     (ex_tl_i.memop_wr),
        .load_i      (ex_tl_i.memop_rd),
        .drain_i     (sb_drain),
        .addr_i      (ex_tl_i.alu_res),
        .data_i      (ex_tl_i.st_data),
        .type_i      (ex_tl_i.memop_type),
        .hit_o       (sb_hit),
        .trouble_o   (sb_trouble),
        .load_data_o (sb_load_data),
        .head_o      (sb_head)
    );

    // Hazard FSM; a cleared trouble state behaves like idle for the held op
    always_comb begin
        state_d  = state_q;
        hazard   = 1'b0;
        miss_req = 1'b0;
        sb_drain = 1'b0;
        case (state_q)
            tl_pkg::TL_IDLE, tl_pkg::HAZARD_SB_TROUBLE: begin
                if (sb_trouble) begin
                    hazard   = 1'b1;
                    state_d  = tl_pkg::HAZARD_SB_TROUBLE;
                    sb_drain = (state_q == tl_pkg::HAZARD_SB_TROUBLE) && sb_head.valid;
                end else if (load_miss) begin
                    hazard   = 1'b1;
                    miss_req = 1'b1;
                    state_d  = tl_pkg::HAZARD_DC_MISS;
                end else begin
                    state_d  = tl_pkg::TL_IDLE;
                    sb_drain = !memop && sb_head.valid;   // Idle slot drains the head
                end
            end
            tl_pkg::HAZARD_DC_MISS: begin
                hazard   = 1'b1;
                miss_req = 1'b1;
                if (mmu_data_rdy_i) state_d = tl_pkg::TL_IDLE;
            end
            default: state_d = tl_pkg::TL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= tl_pkg::TL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next bundle; anything absorbed or served by the buffer skips memory
    always_comb begin
        mem_d.alu_res    = ex_tl_i.alu_res;
        mem_d.rf_we      = ex_tl_i.rf_we;
        mem_d.rf_waddr   = ex_tl_i.rf_waddr;
        mem_d.addr_index = dc_hit ? dc_index : '0;
        mem_d.memop_rd   = ex_tl_i.memop_rd && !sb_hit;
        mem_d.memop_wr   = 1'b0;                      // Stores leave through the drain port
        mem_d.sign_ext   = ex_tl_i.sign_ext;
        mem_d.memop_type = ex_tl_i.memop_type;
        mem_d.tkbr       = ex_tl_i.tkbr;
        mem_d.new_pc     = ex_tl_i.new_pc;
        mem_d.sb_hit     = sb_hit || ex_tl_i.memop_wr;
        mem_d.sb_data    = sb_hit ? sb_load_data : '0;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_q <= '0;
        end else if (hazard) begin
            mem_q.rf_we    <= 1'b0;   // Bubble
            mem_q.memop_rd <= 1'b0;
            mem_q.memop_wr <= 1'b0;
            mem_q.tkbr     <= 1'b0;
            mem_q.sb_hit   <= 1'b0;
        end else begin
            mem_q <= mem_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flush_q <= '0;
        end else if (sb_drain) begin
            flush_q <= sb_head;
        end else begin
            flush_q <= '0;
        end
    end

    assign tl_mem_o          = mem_q;
    assign sb_flush_o        = flush_q;
    assign mmu_miss_o        = miss_req;
    assign mmu_addr_o        = ex_tl_i.alu_res;
    assign pipeline_hazard_o = hazard;

    // Request and its address held across the whole MMU round trip
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mmu_miss_o && !mmu_data_rdy_i) |=> (mmu_miss_o && $stable(mmu_addr_o)))
        else $error("tl_stage: MMU request dropped or changed before ready");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ex_tl_i.memop_rd && ex_tl_i.memop_wr))
        else $error("tl_stage: execute sent a load and a store at once");

endmodule

// File: tl_tb.sv
module tl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Six short tests, each well under 60 cycles even with the slowest MMU answer
    localparam int MAX_CYCLES = 400;

    logic                             clk_i;
    logic                             rst_n_i;
    tl_pkg::ex_tl_t                   ex_tl_i;
    logic                             mmu_data_rdy_i;
    logic [tl_pkg::DC_INDEX_SIZE-1:0] mmu_lru_index_i;
    tl_pkg::tl_mem_t                  tl_mem_o;
    tl_pkg::sb_flush_t                sb_flush_o;
    logic                             mmu_miss_o;
    logic [tl_pkg::WORD_SIZE-1:0]     mmu_addr_o;
    logic                             pipeline_hazard_o;

    logic [tl_pkg::DC_INDEX_SIZE-1:0] lru_sel;          // Line the MMU model fills
    tl_pkg::sb_flush_t                exp_flushes[$];   // Drains still to come, in order
    int                               errors = 0;
    int                               checks = 0;
    int                               tests = 0;
    int                               test_base = 0;
    int                               cycles = 0;

    tl_stage uut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ex_tl_i           (ex_tl_i),
        .mmu_data_rdy_i    (mmu_data_rdy_i),
        .mmu_lru_index_i   (mmu_lru_index_i),
        .tl_mem_o          (tl_mem_o),
        .sb_flush_o        (sb_flush_o),
        .mmu_miss_o        (mmu_miss_o),
        .mmu_addr_o        (mmu_addr_o),
        .pipeline_hazard_o (pipeline_hazard_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic tl_pkg::ex_tl_t make_op(input logic rd, input logic wr,
                                              input tl_pkg::memop_type_e size,
                                              input logic [31:0] addr, input logic [31:0] data);
        tl_pkg::ex_tl_t op;
        op            = '0;
        op.alu_res    = addr;
        op.rf_we      = rd;
        op.rf_waddr   = 5'd9;
        op.st_data    = data;
        op.memop_rd   = rd;
        op.memop_wr   = wr;
        op.memop_type = size;
        op.new_pc     = 32'h0000_0400;
        return op;
    endfunction

    // Byte lanes touched by an access of this size at this offset
    function automatic logic [3:0] lane_mask(input tl_pkg::ex_tl_t op);
        case (op.memop_type)
            tl_pkg::BYTE: return 4'b0001 << op.alu_res[1:0];
            tl_pkg::HALF: return op.alu_res[1] ? 4'b1100 : 4'b0011;
            default:      return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] lane_data(input tl_pkg::ex_tl_t op);
        return op.st_data << {op.alu_res[1:0], 3'b000};
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old, input tl_pkg::ex_tl_t op);
        logic [31:0] word;
        logic [31:0] lanes;
        logic [3:0]  mask;
        word  = old;
        lanes = lane_data(op);
        mask  = lane_mask(op);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) word[8*b +: 8] = lanes[8*b +: 8];
        end
        return word;
    endfunction

    function automatic tl_pkg::sb_flush_t drained(input logic [31:0] addr, input logic [3:0] mask,
                                                  input logic [31:0] data);
        tl_pkg::sb_flush_t f;
        f.valid   = 1'b1;
        f.addr    = {addr[31:2], 2'b00};
        f.byte_en = mask;
        f.data    = data;
        return f;
    endfunction

    // Bundle memory should see; fwd marks an access absorbed or served by the store buffer
    function automatic tl_pkg::tl_mem_t expect_mem(input tl_pkg::ex_tl_t op,
                                                   input logic [1:0] idx, input logic fwd,
                                                   input logic [31:0] fwd_data);
        tl_pkg::tl_mem_t m;
        m.alu_res    = op.alu_res;
        m.rf_we      = op.rf_we;
        m.rf_waddr   = op.rf_waddr;
        m.addr_index = idx;
        m.memop_rd   = op.memop_rd && !fwd;
        m.memop_wr   = op.memop_wr && !fwd;
        m.sign_ext   = op.sign_ext;
        m.memop_type = op.memop_type;
        m.tkbr       = op.tkbr;
        m.new_pc     = op.new_pc;
        m.sb_hit     = fwd;
        m.sb_data    = fwd_data;
        return m;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mem(input tl_pkg::tl_mem_t got, input tl_pkg::tl_mem_t exp,
                             input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flush(input tl_pkg::sb_flush_t got, input tl_pkg::sb_flush_t exp,
                               input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Present a bundle and hold it until the stage stops stalling
    task automatic issue_op(input tl_pkg::ex_tl_t op, output int stalls, output bit saw_miss);
        stalls   = 0;
        saw_miss = 1'b0;
        @(posedge clk_i);
        ex_tl_i <= op;
        @(negedge clk_i);
        while (pipeline_hazard_o) begin
            if (mmu_miss_o) begin
                saw_miss = 1'b1;
                check_word(mmu_addr_o, op.alu_res, "mmu_addr_o");
            end else if (saw_miss) begin
                check_bit(mmu_miss_o, 1'b1, "mmu_miss_o");   // Dropped before ready
            end
            stalls++;
            @(negedge clk_i);
        end
    endtask

    task automatic run_idle(input int n);
        int  stalls;
        bit  miss;
        repeat (n) issue_op('0, stalls, miss);
    endtask

    // One idle slot later the previous bundle sits in the output register
    task automatic check_output(input tl_pkg::tl_mem_t exp);
        run_idle(1);
        check_mem(tl_mem_o, exp, "tl_mem_o");
    endtask

    task automatic check_drains_done();
        if (exp_flushes.size() != 0) begin
            flag_error($sformatf("%0d expected stores never drained on sb_flush_o",
                                 exp_flushes.size()));
            exp_flushes.delete();
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_base) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic test_reset();
        check_mem(tl_mem_o, '0, "tl_mem_o");
        check_flush(sb_flush_o, '0, "sb_flush_o");
        check_bit(mmu_miss_o, 1'b0, "mmu_miss_o");
        check_bit(pipeline_hazard_o, 1'b0, "pipeline_hazard_o");
        end_test("reset");
    endtask

    task automatic test_non_mem();
        tl_pkg::ex_tl_t op;
        int             stalls;
        bit             miss;
        op          = make_op(1'b0, 1'b0, tl_pkg::WORD, 32'hdead_beef, 32'h1234_5678);
        op.rf_we    = 1'b1;
        op.rf_waddr = 5'd7;
        op.sign_ext = 1'b1;
        op.tkbr     = 1'b1;
        op.new_pc   = 32'h0000_0080;
        issue_op(op, stalls, miss);
        if (stalls != 0) flag_error("non-memory op raised pipeline_hazard_o");
        check_output(expect_mem(op, 2'd0, 1'b0, '0));
        end_test("non-memory op");
    endtask

    task automatic test_load_miss();
        tl_pkg::ex_tl_t ld1;
        tl_pkg::ex_tl_t ld2;
        int             stalls;
        bit             miss;
        ld1     = make_op(1'b1, 1'b0, tl_pkg::WORD, 32'h0000_1230, '0);
        ld2     = make_op(1'b1, 1'b0, tl_pkg::WORD, 32'h0000_1238, '0);
        lru_sel = 2'd2;
        issue_op(ld1, stalls, miss);
        if (!miss) flag_error("load to an uncached line raised no MMU request");
        if (stalls == 0) flag_error("load miss did not stall the pipeline");
        check_output(expect_mem(ld1, 2'd2, 1'b0, '0));
        issue_op(ld2, stalls, miss);
        if (stalls != 0) flag_error("load to a filled line stalled");
        check_output(expect_mem(ld2, 2'd2, 1'b0, '0));
        end_test("load miss then hit");
    endtask

    task automatic test_forward();
        tl_pkg::ex_tl_t st1;
        tl_pkg::ex_tl_t st2;
        tl_pkg::ex_tl_t ld;
        logic [31:0]    word;
        int             stalls;
        bit             miss;
        st1  = make_op(1'b0, 1'b1, tl_pkg::WORD, 32'h0000_0100, 32'h1122_3344);
        st2  = make_op(1'b0, 1'b1, tl_pkg::BYTE, 32'h0000_0102, 32'h0000_00ab);
        ld   = make_op(1'b1, 1'b0, tl_pkg::WORD, 32'h0000_0100, '0);
        word = merge_word(merge_word('0, st1), st2);
        exp_flushes.push_back(drained(st1.alu_res, lane_mask(st1) | lane_mask(st2), word));
        issue_op(st1, stalls, miss);
        issue_op(st2, stalls, miss);
        issue_op(ld, stalls, miss);
        if (stalls != 0) flag_error("load covered by the store buffer stalled");
        check_output(expect_mem(ld, 2'd0, 1'b1, word));
        run_idle(3);
        check_drains_done();
        end_test("store forwarding");
    endtask

    task automatic test_full();
        tl_pkg::ex_tl_t st_a;
        tl_pkg::ex_tl_t st_b;
        tl_pkg::ex_tl_t st_c;
        int             stalls;
        bit             miss;
        st_a = make_op(1'b0, 1'b1, tl_pkg::WORD, 32'h0000_0200, 32'haaaa_0001);
        st_b = make_op(1'b0, 1'b1, tl_pkg::WORD, 32'h0000_0300, 32'hbbbb_0002);
        st_c = make_op(1'b0, 1'b1, tl_pkg::WORD, 32'h0000_0400, 32'hcccc_0003);
        exp_flushes.push_back(drained(st_a.alu_res, 4'hf, st_a.st_data));
        exp_flushes.push_back(drained(st_b.alu_res, 4'hf, st_b.st_data));
        exp_flushes.push_back(drained(st_c.alu_res, 4'hf, st_c.st_data));
        issue_op(st_a, stalls, miss);
        issue_op(st_b, stalls, miss);
        issue_op(st_c, stalls, miss);
        if (stalls == 0) flag_error("store into a full store buffer did not stall");
        check_output(expect_mem(st_c, 2'd0, 1'b1, '0));
        run_idle(4);
        check_drains_done();
        end_test("buffer full");
    endtask

    task automatic test_partial();
        tl_pkg::ex_tl_t st;
        tl_pkg::ex_tl_t ld;
        int             stalls;
        bit             miss;
        st      = make_op(1'b0, 1'b1, tl_pkg::BYTE, 32'h0000_0501, 32'h0000_005a);
        ld      = make_op(1'b1, 1'b0, tl_pkg::WORD, 32'h0000_0500, '0);
        lru_sel = 2'd1;
        exp_flushes.push_back(drained(st.alu_res, lane_mask(st), lane_data(st)));
        issue_op(st, stalls, miss);
        issue_op(ld, stalls, miss);
        if (!miss) flag_error("load after partial overlap never reached the MMU");
        check_output(expect_mem(ld, 2'd1, 1'b0, '0));
        run_idle(2);
        check_drains_done();
        end_test("partial coverage");
    endtask

    // MMU model, answers a held request after 1 to 6 cycles
    initial begin
        int delay;
        void'($urandom(4607));
        mmu_data_rdy_i  = 1'b0;
        mmu_lru_index_i = '0;
        forever begin
            @(negedge clk_i);
            if (mmu_miss_o) begin
                delay = $urandom_range(6, 1);
                repeat (delay) @(posedge clk_i);
                mmu_data_rdy_i  <= 1'b1;
                mmu_lru_index_i <= lru_sel;
                @(posedge clk_i);
                mmu_data_rdy_i  <= 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk_i);
            if (rst_n_i && sb_flush_o.valid) begin
                if (exp_flushes.size() == 0) flag_error("sb_flush_o drained an unexpected store");
                else check_flush(sb_flush_o, exp_flushes.pop_front(), "sb_flush_o");
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n_i = 1'b0;
        ex_tl_i = '0;
        lru_sel = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        test_reset();
        test_non_mem();
        test_load_miss();
        test_forward();
        test_full();
        test_partial();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: project.f
tl_pkg.sv
dcache_tag.sv
sb_entry.sv
store_buffer.sv
tl_stage.sv
tl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the tag-lookup stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tl_tb -o tl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
